//--- verilog/sine_table.hex
// One 16-bit two's complement sine sample per line, table address 0 to 31
0000
18F9
30FB
471C
5A82
6A6D
7641
7D8A
7FFF
7D8A
7641
6A6D
5A82
471C
30FB
18F9
0000
E707
CF05
B8E4
A57E
9593
89BF
8276
8001
8276
89BF
9593
A57E
B8E4
CF05
E707

//--- project.f
verilog/audio_pkg.sv
verilog/i2s_frame_timing.sv
verilog/i2s_line_rx.sv
verilog/mic_source.sv
verilog/audio_path_mux.sv
verilog/audio_assess.sv
test/tb_audio_assess.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the audio test path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_audio_assess

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --top-module "$TOP" -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# The sine table is read relative to the RTL folder
(cd verilog && "../obj_dir/V$TOP") > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
fi
echo "Simulation did not pass, see $LOG"
exit 1

//--- test/tb_audio_assess.sv
module tb_audio_assess import audio_pkg::*; ();

  localparam int CLK_HALF      = 10;
  localparam int DRV_DLY       = 2;
  localparam int RESET_CYCLES  = 10;
  localparam int PULSE_TIMEOUT = 400;
  localparam int BCLK_TIMEOUT  = 40;

  logic                  audio_mclk;
  logic                  RESET_n;
  logic                  audio_bclk;
  logic                  audio_wclk;
  logic                  sdata_in;
  logic [SAMPLE_W-1:0]   adc_mic;
  logic                  sw_bypass;
  logic                  sw_obmic_sin;
  logic                  sample_tr;
  logic                  sample_tr_n;
  logic                  sdata_out;
  logic [SAMPLE_W-1:0]   data16_mic;
  logic [ROM_ADDR_W-1:0] rom_addr;
  logic                  rom_ck;
  logic [SAMPLE_W-1:0]   sum_audio;

  // Reference copy of the sine table
  logic [SAMPLE_W-1:0] model_rom [SINE_DEPTH];

  // Left word of the frame the bus model finished last
  logic [SAMPLE_W-1:0] done_left;

  int          test_checks;
  int          test_errors;
  int          total_checks;
  int          total_errors;

  audio_assess i_audio_assess (
    .audio_mclk   (audio_mclk),
    .RESET_n      (RESET_n),
    .audio_bclk   (audio_bclk),
    .audio_wclk   (audio_wclk),
    .sdata_in     (sdata_in),
    .adc_mic      (adc_mic),
    .sw_bypass    (sw_bypass),
    .sw_obmic_sin (sw_obmic_sin),
    .sample_tr    (sample_tr),
    .sample_tr_n  (sample_tr_n),
    .sdata_out    (sdata_out),
    .data16_mic   (data16_mic),
    .rom_addr     (rom_addr),
    .rom_ck       (rom_ck),
    .sum_audio    (sum_audio)
  );

  always #CLK_HALF audio_mclk = ~audio_mclk;

  task automatic next_edge();
    @(posedge audio_mclk);
    #DRV_DLY;
  endtask

  function automatic logic word_bit(input logic [SAMPLE_W-1:0] word, input int idx);
    logic [SAMPLE_W-1:0] shifted;
    shifted = word >> idx;
    return shifted[0];
  endfunction

  // Offset binary to two's complement
  function automatic logic [SAMPLE_W-1:0] to_twos(input logic [SAMPLE_W-1:0] word);
    return {~word[SAMPLE_W-1], word[SAMPLE_W-2:0]};
  endfunction

  // Codec side of the I2S bus
  // bclk runs at a quarter of mclk
  // Line-in data changes on rising bclk and is taken on the next fall
  task automatic drive_bus();
    logic [SAMPLE_W-1:0] left_word;
    logic [SAMPLE_W-1:0] right_word;
    logic                prev_right_lsb;
    int                  k;
    left_word = '0;
    right_word = '0;
    prev_right_lsb = 1'b0;
    forever begin
      for (k = 0; k < FRAME_BITS; k++) begin
        next_edge();
        audio_bclk = 1'b0;
        if (k == 0) begin
          done_left = left_word;
          prev_right_lsb = right_word[0];
          left_word = SAMPLE_W'($urandom);
          right_word = SAMPLE_W'($urandom);
          adc_mic = SAMPLE_W'($urandom);
          audio_wclk = 1'b0;
        end else if (k == FRAME_BITS / 2) begin
          audio_wclk = 1'b1;
        end
        next_edge();
        next_edge();
        audio_bclk = 1'b1;
        // MSB goes out one bit after each wclk edge
        if (k == 0) begin
          sdata_in = prev_right_lsb;
        end else if (k <= SAMPLE_W) begin
          sdata_in = word_bit(left_word, SAMPLE_W - k);
        end else begin
          sdata_in = word_bit(right_word, FRAME_BITS - k);
        end
        next_edge();
      end
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t: no %s seen within the expected time", $time, what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic wait_pulse(input bit right_start, input string what);
    int n;
    n = 0;
    @(negedge audio_mclk);
    while ((right_start ? sample_tr_n : sample_tr) !== 1'b1 && n < PULSE_TIMEOUT) begin
      n++;
      @(negedge audio_mclk);
    end
    if ((right_start ? sample_tr_n : sample_tr) !== 1'b1) begin
      stop_on_timeout(what);
    end
  endtask

  // Returns at the first negedge that sees bclk high after a low
  task automatic wait_bclk_rise();
    int n;
    n = 0;
    while (audio_bclk !== 1'b0 && n < BCLK_TIMEOUT) begin
      n++;
      @(negedge audio_mclk);
    end
    while (audio_bclk !== 1'b1 && n < BCLK_TIMEOUT) begin
      n++;
      @(negedge audio_mclk);
    end
    if (audio_bclk !== 1'b1) begin
      stop_on_timeout("rising edge on bclk");
    end
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    test_checks++;
    if (got !== expected) begin
      test_errors++;
      $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s done: %0d checks, %0d mismatches", name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic set_switches(input logic bypass, input logic sine);
    next_edge();
    sw_bypass = bypass;
    sw_obmic_sin = sine;
  endtask

  initial begin
    logic [SAMPLE_W-1:0] expected;
    logic [SAMPLE_W-1:0] collected;
    logic [4:0]          model_addr;
    logic [4:0]          next_addr;
    int                  i;
    int                  b;
    audio_mclk = 1'b0;
    RESET_n = 1'b0;
    audio_bclk = 1'b0;
    audio_wclk = 1'b0;
    sdata_in = 1'b0;
    adc_mic = '0;
    sw_bypass = 1'b0;
    sw_obmic_sin = 1'b0;
    done_left = '0;
    collected = '0;
    test_checks = 0;
    test_errors = 0;
    total_checks = 0;
    total_errors = 0;
    void'($urandom(32'h666f));
    $readmemh(SINE_FILE, model_rom);
    repeat (RESET_CYCLES) @(posedge audio_mclk);
    #DRV_DLY;
    RESET_n = 1'b1;

    @(negedge audio_mclk);
    check_value(32'(sum_audio), 32'h0, "sum_audio after reset");
    check_value(32'(data16_mic), 32'h0, "data16_mic after reset");
    check_value(32'(rom_addr), 32'h0, "rom_addr after reset");
    check_value(32'(rom_ck), 32'h0, "rom_ck after reset");
    check_value(32'(sample_tr), 32'h0, "sample_tr after reset");
    check_value(32'(sample_tr_n), 32'h0, "sample_tr_n after reset");
    end_test("Reset");

    fork
      drive_bus();
    join_none

    set_switches(1'b1, 1'b0);
    // First frame of the stream is not checked
    wait_pulse(1'b0, "frame start pulse");
    for (i = 0; i < 20; i++) begin
      wait_pulse(1'b0, "frame start pulse");
      expected = done_left;
      repeat (2) @(negedge audio_mclk);
      check_value(32'(sum_audio), 32'(expected), $sformatf("line-in word, frame %0d", i));
    end
    end_test("Line-in capture");

    for (i = 0; i < 8 * FRAME_BITS; i++) begin
      @(negedge audio_mclk);
      check_value(32'(sdata_out), 32'(sdata_in), "sdata_out follows sdata_in in bypass");
    end
    end_test("Bypass loop");

    set_switches(1'b0, 1'b0);
    for (i = 0; i < 16; i++) begin
      wait_pulse(1'b1, "right channel start pulse");
      expected = to_twos(adc_mic);
      repeat (2) @(negedge audio_mclk);
      check_value(32'(sum_audio), 32'(expected), $sformatf("microphone word, frame %0d", i));
    end
    end_test("External microphone");

    wait_pulse(1'b0, "frame start pulse");
    set_switches(1'b0, 1'b1);
    model_addr = '0;
    // More than one pass so the address wraps
    for (i = 0; i < 40; i++) begin
      wait_pulse(1'b1, "right channel start pulse");
      next_addr = model_addr + 5'd1;
      @(negedge audio_mclk);
      check_value(32'(rom_ck), 32'h1, "rom_ck after table step");
      @(negedge audio_mclk);
      check_value(32'(data16_mic), 32'(model_rom[model_addr]),
                  $sformatf("sine word at address %0d", model_addr));
      check_value(32'(rom_addr), 32'(next_addr), "rom_addr after table step");
      model_addr = next_addr;
    end
    end_test("Sine source");

    wait_pulse(1'b0, "frame start pulse");
    set_switches(1'b0, 1'b0);
    for (i = 0; i < 8; i++) begin
      wait_pulse(1'b1, "right channel start pulse");
      expected = to_twos(adc_mic);
      wait_pulse(1'b0, "frame start pulse");
      // Bit position 0 rises first
      wait_bclk_rise();
      for (b = 0; b < SAMPLE_W; b++) begin
        wait_bclk_rise();
        collected = {collected[SAMPLE_W-2:0], sdata_out};
      end
      check_value(32'(collected), 32'(expected), $sformatf("serial word, pass %0d", i));
    end
    end_test("Serialization");

    $display("Checks passed: %0d, failed: %0d", total_checks - total_errors, total_errors);
    if (total_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/audio_assess.sv
module audio_assess import audio_pkg::*; (
  input  logic                  audio_mclk,
  input  logic                  RESET_n,
  input  logic                  audio_bclk,
  input  logic                  audio_wclk,
  input  logic                  sdata_in,
  input  logic [SAMPLE_W-1:0]   adc_mic,
  input  logic                  sw_bypass,
  input  logic                  sw_obmic_sin,
  output logic                  sample_tr,
  output logic                  sample_tr_n,
  output logic                  sdata_out,
  output logic [SAMPLE_W-1:0]   data16_mic,
  output logic [ROM_ADDR_W-1:0] rom_addr,
  output logic                  rom_ck,
  output logic [SAMPLE_W-1:0]   sum_audio
);

  logic                bclk_fall;
  logic [CNT_W-1:0]    bit_cnt;
  logic [SAMPLE_W-1:0] line_sample;

  i2s_frame_timing i_frame_timing (
    .audio_mclk  (audio_mclk),
    .RESET_n     (RESET_n),
    .audio_bclk  (audio_bclk),
    .audio_wclk  (audio_wclk),
    .sample_tr   (sample_tr),
    .sample_tr_n (sample_tr_n),
    .bclk_fall   (bclk_fall),
    .bit_cnt     (bit_cnt)
  );

  i2s_line_rx i_line_rx (
    .audio_mclk  (audio_mclk),
    .RESET_n     (RESET_n),
    .sdata_in    (sdata_in),
    .bclk_fall   (bclk_fall),
    .sample_tr   (sample_tr),
    .bit_cnt     (bit_cnt),
    .line_sample (line_sample)
  );

  // Microphone word is also brought out as data16_mic
  mic_source i_mic_source (
    .audio_mclk   (audio_mclk),
    .RESET_n      (RESET_n),
    .sample_tr_n  (sample_tr_n),
    .sw_obmic_sin (sw_obmic_sin),
    .adc_mic      (adc_mic),
    .mic_data     (data16_mic),
    .rom_addr     (rom_addr),
    .rom_ck       (rom_ck)
  );

  audio_path_mux i_path_mux (
    .audio_mclk  (audio_mclk),
    .RESET_n     (RESET_n),
    .sw_bypass   (sw_bypass),
    .sdata_in    (sdata_in),
    .line_sample (line_sample),
    .mic_data    (data16_mic),
    .bit_cnt     (bit_cnt),
    .bclk_fall   (bclk_fall),
    .sdata_out   (sdata_out),
    .sum_audio   (sum_audio)
  );

endmodule

//--- verilog/audio_path_mux.sv
module audio_path_mux import audio_pkg::*; (
  input  logic                audio_mclk,
  input  logic                RESET_n,
  input  logic                sw_bypass,
  input  logic                sdata_in,
  input  logic [SAMPLE_W-1:0] line_sample,
  input  logic [SAMPLE_W-1:0] mic_data,
  input  logic [CNT_W-1:0]    bit_cnt,
  input  logic                bclk_fall,
  output logic                sdata_out,
  output logic [SAMPLE_W-1:0] sum_audio
);

  localparam int BIT_IDX_W = $clog2(SAMPLE_W);

  logic [BIT_IDX_W-1:0] mic_bit_idx;
  logic                 sd_mic;

  // On a bclk fall the counter steps from bit_cnt to bit_cnt + 1
  // At count n the line carries bit 15 - ((n - 1) mod 16)
  // so the bit for the new count is 15 - (bit_cnt mod 16)
  // Both halves repeat the same word
  assign mic_bit_idx = BIT_IDX_W'(SAMPLE_W - 1) - bit_cnt[BIT_IDX_W-1:0];

  // Bit is registered together with the counter step
  always_ff @(posedge audio_mclk) begin
    if (!RESET_n) begin
      sd_mic <= 1'b0;
    end else if (bclk_fall) begin
      sd_mic <= mic_data[mic_bit_idx];
    end
  end

  // Bypass loops the codec line-in straight back
  assign sdata_out = sw_bypass ? sdata_in : sd_mic;

  // Monitor word follows the path on the serial output
  assign sum_audio = sw_bypass ? line_sample : mic_data;

endmodule

//--- verilog/mic_source.sv
module mic_source import audio_pkg::*; (
  input  logic                  audio_mclk,
  input  logic                  RESET_n,
  input  logic                  sample_tr_n,
  input  logic                  sw_obmic_sin,
  input  logic [SAMPLE_W-1:0]   adc_mic,
  output logic [SAMPLE_W-1:0]   mic_data,
  output logic [ROM_ADDR_W-1:0] rom_addr,
  output logic                  rom_ck
);

  localparam int TBL_AW = $clog2(SINE_DEPTH);

  logic [SAMPLE_W-1:0] sine_rom [SINE_DEPTH];
  logic [SAMPLE_W-1:0] ext_word;
  logic [SAMPLE_W-1:0] sine_word;
  mic_sel_t            mic_sel;

  initial begin
    $readmemh(SINE_FILE, sine_rom);
  end

  assign mic_sel = sw_obmic_sin ? MIC_SINE : MIC_EXT;

  // ADC gives offset binary, flipping the MSB makes it two's complement
  assign ext_word = {~adc_mic[SAMPLE_W-1], adc_mic[SAMPLE_W-2:0]};

  // Only the low address bits reach the table
  assign sine_word = sine_rom[rom_addr[TBL_AW-1:0]];

  // One word per frame, taken at the right channel start
  always_ff @(posedge audio_mclk) begin
    if (!RESET_n) begin
      mic_data <= '0;
      rom_addr <= '0;
    end else if (sample_tr_n) begin
      case (mic_sel)
        MIC_SINE: begin
          mic_data <= sine_word;
          // Step through the table, wrapping after the last entry
          if (rom_addr == ROM_ADDR_W'(SINE_DEPTH - 1)) begin
            rom_addr <= '0;
          end else begin
            rom_addr <= rom_addr + 1'b1;
          end
        end
        default: begin
          mic_data <= ext_word;
        end
      endcase
    end
  end

  // Step strobe for the test header
  always_ff @(posedge audio_mclk) begin
    if (!RESET_n) begin
      rom_ck <= 1'b0;
    end else begin
      rom_ck <= sample_tr_n;
    end
  end

endmodule

//--- verilog/i2s_line_rx.sv
module i2s_line_rx import audio_pkg::*; (
  input  logic                audio_mclk,
  input  logic                RESET_n,
  input  logic                sdata_in,
  input  logic                bclk_fall,
  input  logic                sample_tr,
  input  logic [CNT_W-1:0]    bit_cnt,
  output logic [SAMPLE_W-1:0] line_sample
);

  localparam int BIT_IDX_W = $clog2(SAMPLE_W);

  logic [SAMPLE_W-1:0]  shift_word;
  logic [BIT_IDX_W-1:0] bit_pos;
  logic                 in_left_slot;

  // Counts 1..16 carry the left word MSB first after the one-bit I2S delay
  assign in_left_slot = (bit_cnt >= CNT_W'(1)) && (bit_cnt <= CNT_W'(SAMPLE_W));

  // Count 1 lands in the MSB and count 16 in the LSB
  assign bit_pos = BIT_IDX_W'(CNT_W'(SAMPLE_W) - bit_cnt);

  always_ff @(posedge audio_mclk) begin
    if (!RESET_n) begin
      shift_word <= '0;
    end else if (bclk_fall && in_left_slot) begin
      shift_word[bit_pos] <= sdata_in;
    end
  end

  // Only complete words are published and held for the next whole frame
  always_ff @(posedge audio_mclk) begin
    if (!RESET_n) begin
      line_sample <= '0;
    end else if (sample_tr) begin
      line_sample <= shift_word;
    end
  end

endmodule

//--- verilog/i2s_frame_timing.sv
module i2s_frame_timing import audio_pkg::*; (
  input  logic             audio_mclk,
  input  logic             RESET_n,
  input  logic             audio_bclk,
  input  logic             audio_wclk,
  output logic             sample_tr,
  output logic             sample_tr_n,
  output logic             bclk_fall,
  output logic [CNT_W-1:0] bit_cnt
);

  // First stage takes the codec clocks into the mclk domain
  logic bclk_s;
  logic wclk_s;

  // Second stage holds last cycle's value for edge detection
  logic bclk_d;
  logic wclk_d;

  always_ff @(posedge audio_mclk) begin
    if (!RESET_n) begin
      bclk_s <= 1'b0;
      wclk_s <= 1'b0;
      bclk_d <= 1'b0;
      wclk_d <= 1'b0;
    end else begin
      bclk_s <= audio_bclk;
      wclk_s <= audio_wclk;
      bclk_d <= bclk_s;
      wclk_d <= wclk_s;
    end
  end

  // Frame start at the left channel, i.e. falling wclk
  assign sample_tr = !wclk_s && wclk_d;

  // Right channel start
  assign sample_tr_n = wclk_s && !wclk_d;

  assign bclk_fall = !bclk_s && bclk_d;

  // Position within the frame
  // Frame start wins over a bclk fall seen in the same cycle
  always_ff @(posedge audio_mclk) begin
    if (!RESET_n) begin
      bit_cnt <= '0;
    end else if (sample_tr) begin
      bit_cnt <= '0;
    end else if (bclk_fall) begin
      if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
        // Stay inside one frame if wclk goes missing
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

//--- verilog/audio_pkg.sv
package audio_pkg;

  // Codec sample format, left justified in the I2S slot
  localparam int SAMPLE_W = 16;

  // One wclk frame in bclk periods
  // Left half while wclk is low, right half while wclk is high
  localparam int FRAME_BITS = 32;

  // Bit counter within the frame, wide enough for FRAME_BITS
  localparam int CNT_W = 6;

  // Sine test source
  localparam int SINE_DEPTH = 32;

  // Address port as wired to the board test header
  localparam int ROM_ADDR_W = 8;

  // Table contents, one hex word per line
  localparam string SINE_FILE = "sine_table.hex";

  // Microphone word source, decoded from the sine switch
  typedef enum logic {
    MIC_EXT,
    MIC_SINE
  } mic_sel_t;

endpackage
